/* verilog/mem_pkg.sv */
package mem_pkg;

    localparam int LINE_BITS   = 256;
    localparam int BEAT_BITS   = 64;
    localparam int ADDR_BITS   = 32;
    localparam int BEATS       = 4;
    localparam int MEM_LINES   = 64;
    localparam int MEM_LATENCY = 3;

    // derived geometry.
    localparam int OFFSET_BITS   = $clog2(LINE_BITS / 8);   // byte offset inside a line.
    localparam int LINE_IDX_BITS = $clog2(MEM_LINES);
    localparam int BEAT_IDX_BITS = $clog2(BEATS);
    localparam int LAT_BITS      = $clog2(MEM_LATENCY);

    localparam logic [BEAT_IDX_BITS-1:0] LAST_BEAT = BEAT_IDX_BITS'(BEATS - 1);
    // idle cycle of the sram counts as the first latency cycle.
    localparam logic [LAT_BITS-1:0]      LAT_LOAD  = LAT_BITS'(MEM_LATENCY - 2);

    typedef logic [LINE_BITS-1:0] line_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [ADDR_BITS-1:0] addr_t;

endpackage

/* verilog/mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic           clk,
    input  logic           rst,

    input  logic           i_read,
    input  mem_pkg::addr_t i_address,
    output mem_pkg::line_t i_rdata,
    output logic           i_resp,

    input  logic           d_read,
    input  logic           d_write,
    input  mem_pkg::addr_t d_address,
    input  mem_pkg::line_t d_wdata,
    output mem_pkg::line_t d_rdata,
    output logic           d_resp,

    output logic           pmem_read,
    output logic           pmem_write,
    output mem_pkg::addr_t pmem_address,
    output mem_pkg::line_t pmem_wdata,
    input  mem_pkg::line_t pmem_rdata,
    input  logic           pmem_resp,

    output logic           arbiter_idle
);

    typedef enum logic [1:0] {
        IDLE,
        SERVE_I,
        SERVE_D
    } state_t;

    state_t state;
    state_t next_state;
    logic   grant_i;
    logic   grant_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (d_read || d_write) begin
                    next_state = SERVE_D;   // data side has priority.
                end else if (i_read) begin
                    next_state = SERVE_I;
                end
            end
            SERVE_I, SERVE_D: begin
                if (pmem_resp) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // a grant holds from the cycle it is taken in idle until resp.
    assign grant_d = (state == SERVE_D) || (state == IDLE && next_state == SERVE_D);
    assign grant_i = (state == SERVE_I) || (state == IDLE && next_state == SERVE_I);

    assign arbiter_idle = (state == IDLE);

    always_comb begin
        pmem_read    = 1'b0;
        pmem_write   = 1'b0;
        pmem_address = '0;
        pmem_wdata   = '0;
        i_rdata      = '0;
        i_resp       = 1'b0;
        d_rdata      = '0;
        d_resp       = 1'b0;

        if (grant_d) begin
            pmem_address = d_address;
            d_resp       = pmem_resp;
            if (d_read) begin
                pmem_read = 1'b1;
                d_rdata   = pmem_rdata;
            end else begin
                pmem_write = 1'b1;
                pmem_wdata = d_wdata;
            end
        end else if (grant_i) begin
            pmem_address = i_address;
            pmem_read    = 1'b1;   // instruction side never writes.
            i_rdata      = pmem_rdata;
            i_resp       = pmem_resp;
        end
    end

endmodule

/* verilog/line_burst_adaptor.sv */
`timescale 1ns/10ps

module line_burst_adaptor (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              pmem_read,
    input  logic                              pmem_write,
    input  mem_pkg::addr_t                    pmem_address,
    input  mem_pkg::line_t                    pmem_wdata,
    output mem_pkg::line_t                    pmem_rdata,
    output logic                              pmem_resp,

    output logic                              burst_read,
    output logic                              burst_write,
    output logic [mem_pkg::LINE_IDX_BITS-1:0] burst_address,
    output mem_pkg::beat_t                    burst_wdata,
    input  mem_pkg::beat_t                    burst_rdata,
    input  logic                              burst_resp
);

    typedef enum logic [1:0] {
        IDLE,
        BURST,
        DONE
    } state_t;

    state_t                             state;
    logic                               is_write;
    logic [mem_pkg::BEAT_IDX_BITS-1:0]  beat_cnt;
    logic [mem_pkg::LINE_IDX_BITS-1:0]  line_addr;
    mem_pkg::line_t                     wline;
    mem_pkg::line_t                     rline;

    // control state.
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            is_write <= 1'b0;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pmem_read || pmem_write) begin
                        state    <= BURST;
                        is_write <= pmem_write;
                        beat_cnt <= '0;
                    end
                end
                BURST: begin
                    if (burst_resp) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == mem_pkg::LAST_BEAT) begin
                            state <= DONE;
                        end
                    end
                end
                DONE: begin
                    state <= IDLE;   // resp lasts one cycle.
                end
                default: state <= IDLE;
            endcase
        end
    end

    // payload registers.
    always_ff @(posedge clk) begin
        if (state == IDLE && (pmem_read || pmem_write)) begin
            line_addr <= pmem_address[mem_pkg::OFFSET_BITS +: mem_pkg::LINE_IDX_BITS];
            wline     <= pmem_wdata;
        end
        if (state == BURST && burst_resp && !is_write) begin
            // lowest beat arrives first and ends up at the bottom.
            rline <= {burst_rdata, rline[mem_pkg::LINE_BITS-1:mem_pkg::BEAT_BITS]};
        end
    end

    assign burst_read    = (state == BURST) && !is_write;
    assign burst_write   = (state == BURST) && is_write;
    assign burst_address = line_addr;
    assign burst_wdata   = wline[beat_cnt * mem_pkg::BEAT_BITS +: mem_pkg::BEAT_BITS];

    assign pmem_rdata = rline;
    assign pmem_resp  = (state == DONE);

endmodule

/* verilog/burst_sram.sv */
`timescale 1ns/10ps

module burst_sram (
    input  logic                              clk,
    input  logic                              rst,

    input  logic                              burst_read,
    input  logic                              burst_write,
    input  logic [mem_pkg::LINE_IDX_BITS-1:0] burst_address,
    input  mem_pkg::beat_t                    burst_wdata,
    output mem_pkg::beat_t                    burst_rdata,
    output logic                              burst_resp
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        XFER
    } state_t;

    state_t                             state;
    logic [mem_pkg::LAT_BITS-1:0]       lat_cnt;
    logic [mem_pkg::BEAT_IDX_BITS-1:0]  beat_cnt;   // beat acknowledged in xfer.
    logic                               rd_en;
    logic [mem_pkg::BEAT_IDX_BITS-1:0]  rd_beat;
    logic                               wr_en;

    mem_pkg::beat_t mem [mem_pkg::MEM_LINES * mem_pkg::BEATS];

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            lat_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (burst_read || burst_write) begin
                        state   <= WAIT;
                        lat_cnt <= mem_pkg::LAT_LOAD;
                    end
                end
                WAIT: begin
                    if (lat_cnt == '0) begin
                        state    <= XFER;
                        beat_cnt <= '0;
                    end else begin
                        lat_cnt <= lat_cnt - 1'b1;
                    end
                end
                XFER: begin
                    if (beat_cnt == mem_pkg::LAST_BEAT) begin
                        state <= IDLE;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read one beat ahead so the data register lines up with resp.
    always_comb begin
        rd_en   = 1'b0;
        rd_beat = '0;
        if (state == WAIT && lat_cnt == '0) begin
            rd_en = 1'b1;
        end else if (state == XFER && beat_cnt != mem_pkg::LAST_BEAT) begin
            rd_en   = 1'b1;
            rd_beat = beat_cnt + 1'b1;
        end
    end

    assign wr_en = (state == XFER) && burst_write;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{burst_address, beat_cnt}] <= burst_wdata;
        end
        if (rd_en) begin
            burst_rdata <= mem[{burst_address, rd_beat}];
        end
    end

    assign burst_resp = (state == XFER);

endmodule

/* verilog/mem_subsystem.sv */
`timescale 1ns/10ps

module mem_subsystem (
    input  logic           clk,
    input  logic           rst,

    input  logic           i_read,
    input  mem_pkg::addr_t i_address,
    output mem_pkg::line_t i_rdata,
    output logic           i_resp,

    input  logic           d_read,
    input  logic           d_write,
    input  mem_pkg::addr_t d_address,
    input  mem_pkg::line_t d_wdata,
    output mem_pkg::line_t d_rdata,
    output logic           d_resp,

    output logic           arbiter_idle
);

    // line port between arbiter and adaptor.
    logic                              pmem_read;
    logic                              pmem_write;
    mem_pkg::addr_t                    pmem_address;
    mem_pkg::line_t                    pmem_wdata;
    mem_pkg::line_t                    pmem_rdata;
    logic                              pmem_resp;

    // burst port between adaptor and sram.
    logic                              burst_read;
    logic                              burst_write;
    logic [mem_pkg::LINE_IDX_BITS-1:0] burst_address;
    mem_pkg::beat_t                    burst_wdata;
    mem_pkg::beat_t                    burst_rdata;
    logic                              burst_resp;

    mem_arbiter i_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_read       (i_read),
        .i_address    (i_address),
        .i_rdata      (i_rdata),
        .i_resp       (i_resp),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_address    (d_address),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .d_resp       (d_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .arbiter_idle (arbiter_idle)
    );

    line_burst_adaptor i_adaptor (
        .clk           (clk),
        .rst           (rst),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .pmem_address  (pmem_address),
        .pmem_wdata    (pmem_wdata),
        .pmem_rdata    (pmem_rdata),
        .pmem_resp     (pmem_resp),
        .burst_read    (burst_read),
        .burst_write   (burst_write),
        .burst_address (burst_address),
        .burst_wdata   (burst_wdata),
        .burst_rdata   (burst_rdata),
        .burst_resp    (burst_resp)
    );

    burst_sram i_sram (
        .clk           (clk),
        .rst           (rst),
        .burst_read    (burst_read),
        .burst_write   (burst_write),
        .burst_address (burst_address),
        .burst_wdata   (burst_wdata),
        .burst_rdata   (burst_rdata),
        .burst_resp    (burst_resp)
    );

endmodule

/* tb/tb_mem_subsystem.sv */
`timescale 1ns/10ps

module tb_mem_subsystem;

    localparam int NUM_TESTS  = 14;
    localparam int RESP_DELAY = mem_pkg::MEM_LATENCY + mem_pkg::BEATS + 1;

    // table row with primary port, direction, address, second port, its address and order check.
    typedef struct packed {
        logic        port_d;
        logic        write;
        logic [31:0] addr;
        logic        both;
        logic [31:0] addr2;
        logic        order;
    } test_t;

    logic           clk;
    logic           rst;
    logic           i_read;
    mem_pkg::addr_t i_address;
    mem_pkg::line_t i_rdata;
    logic           i_resp;
    logic           d_read;
    logic           d_write;
    mem_pkg::addr_t d_address;
    mem_pkg::line_t d_wdata;
    mem_pkg::line_t d_rdata;
    logic           d_resp;
    logic           arbiter_idle;

    test_t          tests [NUM_TESTS];
    mem_pkg::line_t ref_mem [mem_pkg::MEM_LINES];
    logic [31:0]    lcg_state = 32'd98219;
    int             err_count = 0;
    int             pass_count = 0;
    int             fail_count = 0;

    mem_subsystem i_dut (
        .clk          (clk),
        .rst          (rst),
        .i_read       (i_read),
        .i_address    (i_address),
        .i_rdata      (i_rdata),
        .i_resp       (i_resp),
        .d_read       (d_read),
        .d_write      (d_write),
        .d_address    (d_address),
        .d_wdata      (d_wdata),
        .d_rdata      (d_rdata),
        .d_resp       (d_resp),
        .arbiter_idle (arbiter_idle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic mem_pkg::line_t make_line();
        mem_pkg::line_t line;
        for (int w = 0; w < 8; w++) begin
            line[w*32 +: 32] = lcg_next();
        end
        return line;
    endfunction

    task automatic check_value(input logic [255:0] actual, input logic [255:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("ERR %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (err_count == err_before) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, err_count - err_before);
        end
    endtask

    task automatic check_reset();
        int err_before;
        err_before = err_count;
        repeat (4) begin
            @(negedge clk);
            check_value(256'(arbiter_idle), 256'(1), "arbiter_idle after reset");
            check_value(256'(i_resp), '0, "i_resp with no request");
            check_value(256'(d_resp), '0, "d_resp with no request");
        end
        report_test("reset", err_before);
    endtask

    task automatic run_test(input int idx);
        test_t          t;
        mem_pkg::line_t wline;
        logic [31:0]    i_addr;
        bit             d_busy;
        bit             i_busy;
        int             cyc;
        int             d_start;
        int             i_start;
        int             d_done;
        int             i_done;
        int             err_before;
        t          = tests[idx];
        err_before = err_count;
        d_busy     = t.port_d;
        i_busy     = !t.port_d || t.both;
        i_addr     = t.both ? t.addr2 : t.addr;
        wline      = make_line();
        d_start    = 0;
        i_start    = 0;
        d_done     = 0;
        i_done     = 0;
        @(posedge clk);
        if (d_busy) begin
            d_address <= t.addr;
            d_read    <= !t.write;
            d_write   <= t.write;
            d_wdata   <= t.write ? wline : '0;
        end
        if (i_busy) begin
            i_address <= i_addr;
            i_read    <= 1'b1;
        end
        cyc = 0;
        while (d_busy || i_busy) begin
            @(negedge clk);
            check_value(256'(d_resp && !d_busy), '0, "d_resp without a held request");
            check_value(256'(i_resp && !i_busy), '0, "i_resp without a held request");
            // each request starts with the arbiter idle.
            if ((d_busy && cyc == d_start) || (i_busy && cyc == i_start)) begin
                check_value(256'(arbiter_idle), 256'(1), "arbiter_idle at request start");
            end
            if (d_busy && d_resp) begin
                check_value(256'(cyc - d_start), 256'(RESP_DELAY), "data resp latency");
                if (t.write) begin
                    ref_mem[t.addr[10:5]] = wline;
                end else begin
                    check_value(d_rdata, ref_mem[t.addr[10:5]], "data read line");
                end
                d_done = cyc;
                d_busy = 1'b0;
                if (i_busy) begin
                    i_start = cyc + 1;   // waiting instruction request goes next.
                end
            end
            if (i_busy && i_resp) begin
                check_value(256'(cyc - i_start), 256'(RESP_DELAY), "instruction resp latency");
                check_value(i_rdata, ref_mem[i_addr[10:5]], "instruction read line");
                i_done = cyc;
                i_busy = 1'b0;
            end
            @(posedge clk);
            if (!d_busy) begin
                d_read  <= 1'b0;
                d_write <= 1'b0;
            end
            if (!i_busy) begin
                i_read <= 1'b0;
            end
            cyc++;
        end
        if (t.order) begin
            check_value(256'(d_done < i_done), 256'(1), "d_resp not ahead of i_resp");
        end
        report_test($sformatf("%0d (%s %s %h)", idx, t.port_d ? "data" : "instr",
                              t.write ? "write" : "read", t.addr), err_before);
    endtask

    initial begin
        //           port_d write  addr          both  addr2         order
        tests[0]  = '{1'b1, 1'b1, 32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0};
        tests[1]  = '{1'b1, 1'b0, 32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0};
        tests[2]  = '{1'b0, 1'b0, 32'h0000_005c, 1'b0, 32'h0000_0000, 1'b0};
        tests[3]  = '{1'b0, 1'b0, 32'habcd_f840, 1'b0, 32'h0000_0000, 1'b0};
        tests[4]  = '{1'b1, 1'b1, 32'h0000_07e0, 1'b0, 32'h0000_0000, 1'b0};
        tests[5]  = '{1'b1, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0};
        tests[6]  = '{1'b1, 1'b1, 32'h0000_0120, 1'b0, 32'h0000_0000, 1'b0};
        tests[7]  = '{1'b1, 1'b1, 32'h0000_0200, 1'b1, 32'h0000_07e0, 1'b1};
        tests[8]  = '{1'b1, 1'b0, 32'h0000_0120, 1'b1, 32'h0000_0000, 1'b1};
        tests[9]  = '{1'b1, 1'b0, 32'h0000_0040, 1'b0, 32'h0000_0000, 1'b0};
        tests[10] = '{1'b0, 1'b0, 32'h0000_07e0, 1'b0, 32'h0000_0000, 1'b0};
        tests[11] = '{1'b1, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000, 1'b0};
        tests[12] = '{1'b0, 1'b0, 32'h0000_0120, 1'b0, 32'h0000_0000, 1'b0};
        tests[13] = '{1'b1, 1'b0, 32'h0000_0200, 1'b0, 32'h0000_0000, 1'b0};

        rst       <= 1'b1;
        i_read    <= 1'b0;
        i_address <= '0;
        d_read    <= 1'b0;
        d_write   <= 1'b0;
        d_address <= '0;
        d_wdata   <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        check_reset();
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // watchdog.
    initial begin
        repeat (NUM_TESTS * 40) @(posedge clk);
        $display("simulation timed out after %0d cycles", NUM_TESTS * 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* mem_subsystem.f */
verilog/mem_pkg.sv
verilog/mem_arbiter.sv
verilog/line_burst_adaptor.sv
verilog/burst_sram.sv
verilog/mem_subsystem.sv
tb/tb_mem_subsystem.sv

/* run.sh */
#!/bin/sh
# Compile and run the memory subsystem testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_subsystem -f mem_subsystem.f -o tb_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && exit 0 || exit 1
